// ==== design/pu_pkg.sv ====
/* Shared widths, pi1 bus operations, sequencer states, opcodes
   and the two-view instruction word union. */
package pu_pkg;

	localparam int ARCHBITSZ = 32;
	localparam int ADDRBITSZ = 30;
	localparam int GPRCNT    = 16;
	localparam int GPRIDXSZ  = 4;

	// pi1 operation codes.
	localparam logic [1:0] MEMNOOP    = 2'b00;
	localparam logic [1:0] MEMWRITEOP = 2'b01;
	localparam logic [1:0] MEMREADOP  = 2'b10;

	localparam logic [1:0] SEQ_FETCH = 2'd0;
	localparam logic [1:0] SEQ_EXEC  = 2'd1;
	localparam logic [1:0] SEQ_MEM   = 2'd2;
	localparam logic [1:0] SEQ_HALT  = 2'd3;

	// Register form opcodes.
	localparam logic [3:0] OPADD  = 4'd0;
	localparam logic [3:0] OPSUB  = 4'd1;
	localparam logic [3:0] OPAND  = 4'd2;
	localparam logic [3:0] OPOR   = 4'd3;
	localparam logic [3:0] OPXOR  = 4'd4;
	localparam logic [3:0] OPSHL  = 4'd5;
	localparam logic [3:0] OPSHR  = 4'd6;

	// Immediate form opcodes, anything above OPHALT also halts.
	localparam logic [3:0] OPADDI = 4'd7;
	localparam logic [3:0] OPLI   = 4'd8;
	localparam logic [3:0] OPLD   = 4'd9;
	localparam logic [3:0] OPST   = 4'd10;
	localparam logic [3:0] OPBZ   = 4'd11;
	localparam logic [3:0] OPHALT = 4'd12;

	typedef struct packed {
		logic [3:0]          opcode;
		logic [GPRIDXSZ-1:0] rd;
		logic [GPRIDXSZ-1:0] ra;
		logic [GPRIDXSZ-1:0] rb;
		logic [15:0]         unused;
	} pu_rform_t;

	typedef struct packed {
		logic [3:0]          opcode;
		logic [GPRIDXSZ-1:0] rd;
		logic [GPRIDXSZ-1:0] ra;
		logic signed [19:0]  imm;
	} pu_iform_t;

	// One instruction word, read either as register or immediate form.
	typedef union packed {
		pu_rform_t r;
		pu_iform_t i;
	} pu_instr_u;

endpackage

// ==== design/pu_sequencer.sv ====
`timescale 1ns/1ps
/* Instruction sequencer: FETCH/EXEC/MEM/HALT state machine, program counter,
   instruction register, pi1 bus master and writeback strobes. */
module pu_sequencer (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic [pu_pkg::ADDRBITSZ-1:0] rstaddr_i,
	output logic [1:0]                   pi1_op_o,
	output logic [pu_pkg::ADDRBITSZ-1:0] pi1_addr_o,
	output logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_o,
	input  logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_i,
	input  logic                         pi1_rdy_i,
	input  logic                         is_load_i,
	input  logic                         is_store_i,
	input  logic                         is_branch_i,
	input  logic                         is_halt_i,
	input  logic                         reg_write_i,
	input  logic [pu_pkg::ADDRBITSZ-1:0] mem_addr_i,
	input  logic                         branch_taken_i,
	input  logic [pu_pkg::ADDRBITSZ-1:0] branch_target_i,
	input  logic [pu_pkg::ARCHBITSZ-1:0] store_data_i,
	output logic [pu_pkg::ARCHBITSZ-1:0] instr_o,
	output logic [pu_pkg::ADDRBITSZ-1:0] pc_o,
	output logic                         wb_en_o,
	output logic                         wb_load_o,
	output logic                         halted_o
);
	import pu_pkg::*;

	logic [1:0]           state_q;
	logic [1:0]           state_d;
	logic                 started_q;
	logic [ADDRBITSZ-1:0] pc_q;
	logic [ADDRBITSZ-1:0] pc_d;
	logic [ARCHBITSZ-1:0] ir_q;
	logic                 fetch_done;
	logic                 mem_access;

	// No fetch goes out until the pc has been taken from rstaddr_i.
	assign fetch_done = (state_q == SEQ_FETCH) && started_q && pi1_rdy_i;
	assign mem_access = is_load_i || is_store_i;

	always_comb begin
		state_d = state_q;
		pc_d = pc_q;
		case (state_q)
			SEQ_FETCH: begin
				if (fetch_done) begin
					state_d = SEQ_EXEC;
				end
			end
			SEQ_EXEC: begin
				if (is_halt_i) begin
					state_d = SEQ_HALT;
				end else begin
					if (is_branch_i && branch_taken_i) begin
						pc_d = branch_target_i;
					end else begin
						pc_d = pc_q + 1'b1;
					end
					state_d = mem_access ? SEQ_MEM : SEQ_FETCH;
				end
			end
			SEQ_MEM: begin
				if (pi1_rdy_i) begin
					state_d = SEQ_FETCH;
				end
			end
			default: begin
				state_d = SEQ_HALT;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= SEQ_FETCH;
			started_q <= 1'b0;
			pc_q <= '0;
		end else begin
			state_q <= state_d;
			started_q <= 1'b1;
			pc_q <= started_q ? pc_d : rstaddr_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fetch_done) begin
			ir_q <= pi1_data_i;
		end
	end

	// Bus request follows the state; all fields hold while rdy is low.
	always_comb begin
		pi1_op_o = MEMNOOP;
		pi1_addr_o = pc_q;
		pi1_data_o = '0;
		case (state_q)
			SEQ_FETCH: begin
				if (started_q) begin
					pi1_op_o = MEMREADOP;
				end
			end
			SEQ_MEM: begin
				pi1_op_o = is_load_i ? MEMREADOP : MEMWRITEOP;
				pi1_addr_o = mem_addr_i;
				pi1_data_o = store_data_i;
			end
			default: begin
				pi1_op_o = MEMNOOP;
			end
		endcase
	end

	// ALU results land at the end of EXEC, load data on the read completion edge.
	assign wb_load_o = (state_q == SEQ_MEM) && is_load_i;
	assign wb_en_o = ((state_q == SEQ_EXEC) && reg_write_i && !is_load_i) ||
		(wb_load_o && pi1_rdy_i);

	assign instr_o = ir_q;
	assign pc_o = pc_q;
	assign halted_o = (state_q == SEQ_HALT);

endmodule

// ==== design/pu_decode.sv ====
`timescale 1ns/1ps
/* Instruction decoder: register indices, sign-extended immediate,
   ALU operation and class flags. */
module pu_decode (
	input  logic [pu_pkg::ARCHBITSZ-1:0] instr_i,
	output logic [pu_pkg::GPRIDXSZ-1:0]  rd_o,
	output logic [pu_pkg::GPRIDXSZ-1:0]  ra_o,
	output logic [pu_pkg::GPRIDXSZ-1:0]  rb_o,
	output logic [pu_pkg::ARCHBITSZ-1:0] imm_o,
	output logic [3:0]                   alu_op_o,
	output logic                         use_imm_o,
	output logic                         reg_write_o,
	output logic                         is_load_o,
	output logic                         is_store_o,
	output logic                         is_branch_o,
	output logic                         is_halt_o
);
	import pu_pkg::*;

	pu_instr_u  instr;
	logic [3:0] opcode;
	logic       is_rform;

	assign instr = instr_i;
	assign opcode = instr.r.opcode;
	assign is_rform = (opcode <= OPSHR);

	// Both forms share opcode, rd and ra.
	assign rd_o = instr.r.rd;
	assign ra_o = instr.r.ra;
	assign rb_o = is_rform ? instr.r.rb : '0;
	assign imm_o = is_rform ? '0 : ARCHBITSZ'(instr.i.imm);
	assign use_imm_o = !is_rform;

	always_comb begin
		alu_op_o = OPADD;
		reg_write_o = 1'b0;
		is_load_o = 1'b0;
		is_store_o = 1'b0;
		is_branch_o = 1'b0;
		is_halt_o = 1'b0;
		case (opcode)
			OPADD, OPSUB, OPAND, OPOR, OPXOR, OPSHL, OPSHR: begin
				alu_op_o = opcode;
				reg_write_o = 1'b1;
			end
			OPADDI: begin
				reg_write_o = 1'b1;
			end
			OPLI: begin
				alu_op_o = OPLI;
				reg_write_o = 1'b1;
			end
			OPLD: begin
				reg_write_o = 1'b1;
				is_load_o = 1'b1;
			end
			OPST: is_store_o = 1'b1;
			OPBZ: is_branch_o = 1'b1;
			// OPHALT and the unassigned codes.
			default: begin
				is_halt_o = 1'b1;
			end
		endcase
	end

endmodule

// ==== design/pu_execute.sv ====
`timescale 1ns/1ps
/* Execute stage: ALU, load/store address adder and branch-if-zero
   evaluation. */
module pu_execute (
	input  logic [3:0]                   alu_op_i,
	input  logic                         use_imm_i,
	input  logic [pu_pkg::ARCHBITSZ-1:0] ra_data_i,
	input  logic [pu_pkg::ARCHBITSZ-1:0] rb_data_i,
	input  logic [pu_pkg::ARCHBITSZ-1:0] imm_i,
	input  logic [pu_pkg::ADDRBITSZ-1:0] pc_i,
	output logic [pu_pkg::ARCHBITSZ-1:0] alu_result_o,
	output logic [pu_pkg::ADDRBITSZ-1:0] mem_addr_o,
	output logic                         branch_taken_o,
	output logic [pu_pkg::ADDRBITSZ-1:0] branch_target_o
);
	import pu_pkg::*;

	logic [ARCHBITSZ-1:0] op_b;
	logic [4:0]           shamt;
	logic [ADDRBITSZ-1:0] imm_word;

	assign op_b = use_imm_i ? imm_i : rb_data_i;
	assign shamt = op_b[4:0];
	assign imm_word = imm_i[ADDRBITSZ-1:0];

	always_comb begin
		case (alu_op_i)
			OPADD: begin
				alu_result_o = ra_data_i + op_b;
			end
			OPSUB: begin
				alu_result_o = ra_data_i - op_b;
			end
			OPAND: begin
				alu_result_o = ra_data_i & op_b;
			end
			OPOR: begin
				alu_result_o = ra_data_i | op_b;
			end
			OPXOR: begin
				alu_result_o = ra_data_i ^ op_b;
			end
			OPSHL: begin
				alu_result_o = ra_data_i << shamt;
			end
			// Logical shift, zeros come in from the top.
			OPSHR: begin
				alu_result_o = ra_data_i >> shamt;
			end
			OPLI: begin
				alu_result_o = imm_i;
			end
			default: begin
				alu_result_o = ra_data_i + op_b;
			end
		endcase
	end

	// Word address, the upper bits of ra are dropped.
	assign mem_addr_o = ra_data_i[ADDRBITSZ-1:0] + imm_word;

	assign branch_taken_o = (ra_data_i == '0);
	assign branch_target_o = pc_i + ADDRBITSZ'(1) + imm_word;

endmodule

// ==== design/pu_result.sv ====
`timescale 1ns/1ps
/* General register file with writeback select between ALU result
   and load data, and three read ports. */
module pu_result (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         wb_en_i,
	input  logic                         wb_load_i,
	input  logic [pu_pkg::GPRIDXSZ-1:0]  rd_i,
	input  logic [pu_pkg::GPRIDXSZ-1:0]  ra_i,
	input  logic [pu_pkg::GPRIDXSZ-1:0]  rb_i,
	input  logic [pu_pkg::ARCHBITSZ-1:0] alu_result_i,
	input  logic [pu_pkg::ARCHBITSZ-1:0] load_data_i,
	output logic [pu_pkg::ARCHBITSZ-1:0] ra_data_o,
	output logic [pu_pkg::ARCHBITSZ-1:0] rb_data_o,
	output logic [pu_pkg::ARCHBITSZ-1:0] rd_data_o
);
	import pu_pkg::*;

	logic [ARCHBITSZ-1:0] gpr_q [GPRCNT];
	logic [ARCHBITSZ-1:0] wb_data;

	assign wb_data = wb_load_i ? load_data_i : alu_result_i;

	// r0 is never written.
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < GPRCNT; i++) begin
				gpr_q[i] <= '0;
			end
		end else if (wb_en_i && (rd_i != '0)) begin
			gpr_q[rd_i] <= wb_data;
		end
	end

	// Index 0 reads zero.
	assign ra_data_o = (ra_i != '0) ? gpr_q[ra_i] : '0;
	assign rb_data_o = (rb_i != '0) ? gpr_q[rb_i] : '0;
	// Store data comes out of the rd port.
	assign rd_data_o = (rd_i != '0) ? gpr_q[rd_i] : '0;

endmodule

// ==== design/pu.sv ====
`timescale 1ns/1ps
/* Processor unit top: sequencer, decode, execute and register result
   blocks on the pi1 memory port. */
module pu (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic [pu_pkg::ADDRBITSZ-1:0] rstaddr_i,
	output logic [1:0]                   pi1_op_o,
	output logic [pu_pkg::ADDRBITSZ-1:0] pi1_addr_o,
	output logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_o,
	input  logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_i,
	input  logic                         pi1_rdy_i,
	output logic                         halted_o
);
	import pu_pkg::*;

	logic [ARCHBITSZ-1:0] instr;
	logic [ADDRBITSZ-1:0] pc;
	logic                 wb_en;
	logic                 wb_load;
	logic [GPRIDXSZ-1:0]  rd;
	logic [GPRIDXSZ-1:0]  ra;
	logic [GPRIDXSZ-1:0]  rb;
	logic [ARCHBITSZ-1:0] imm;
	logic [3:0]           alu_op;
	logic                 use_imm;
	logic                 reg_write;
	logic                 is_load;
	logic                 is_store;
	logic                 is_branch;
	logic                 is_halt;
	logic [ARCHBITSZ-1:0] ra_data;
	logic [ARCHBITSZ-1:0] rb_data;
	logic [ARCHBITSZ-1:0] rd_data;
	logic [ARCHBITSZ-1:0] alu_result;
	logic [ADDRBITSZ-1:0] mem_addr;
	logic                 branch_taken;
	logic [ADDRBITSZ-1:0] branch_target;

	pu_sequencer i_sequencer (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .rstaddr_i(rstaddr_i),
		.pi1_op_o(pi1_op_o), .pi1_addr_o(pi1_addr_o), .pi1_data_o(pi1_data_o),
		.pi1_data_i(pi1_data_i), .pi1_rdy_i(pi1_rdy_i),
		.is_load_i(is_load), .is_store_i(is_store), .is_branch_i(is_branch),
		.is_halt_i(is_halt), .reg_write_i(reg_write),
		.mem_addr_i(mem_addr), .branch_taken_i(branch_taken),
		.branch_target_i(branch_target), .store_data_i(rd_data),
		.instr_o(instr), .pc_o(pc), .wb_en_o(wb_en), .wb_load_o(wb_load),
		.halted_o(halted_o)
	);

	pu_decode i_decode (
		.instr_i(instr), .rd_o(rd), .ra_o(ra), .rb_o(rb), .imm_o(imm),
		.alu_op_o(alu_op), .use_imm_o(use_imm), .reg_write_o(reg_write),
		.is_load_o(is_load), .is_store_o(is_store), .is_branch_o(is_branch),
		.is_halt_o(is_halt)
	);

	pu_execute i_execute (
		.alu_op_i(alu_op), .use_imm_i(use_imm), .ra_data_i(ra_data),
		.rb_data_i(rb_data), .imm_i(imm), .pc_i(pc),
		.alu_result_o(alu_result), .mem_addr_o(mem_addr),
		.branch_taken_o(branch_taken), .branch_target_o(branch_target)
	);

	// Load data goes straight from the bus into the register file.
	pu_result i_result (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .wb_en_i(wb_en), .wb_load_i(wb_load),
		.rd_i(rd), .ra_i(ra), .rb_i(rb), .alu_result_i(alu_result),
		.load_data_i(pi1_data_i), .ra_data_o(ra_data), .rb_data_o(rb_data),
		.rd_data_o(rd_data)
	);

endmodule

// ==== dv/pu_properties.sv ====
`timescale 1ns/1ps
/* Concurrent assertions on the pi1 request and the halted state. */
module pu_properties (
	input logic                         clk_i,
	input logic                         arst_n_i,
	input logic [1:0]                   pi1_op_o,
	input logic [pu_pkg::ADDRBITSZ-1:0] pi1_addr_o,
	input logic [pu_pkg::ARCHBITSZ-1:0] pi1_data_o,
	input logic                         pi1_rdy_i,
	input logic                         halted_o
);
	import pu_pkg::*;

	// A pending request holds every field until rdy.
	request_stable: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		((pi1_op_o != MEMNOOP) && !pi1_rdy_i) |=>
			($stable(pi1_op_o) && $stable(pi1_addr_o) && $stable(pi1_data_o))
	) else $error("pi1 request changed while waiting for pi1_rdy_i");

	idle_when_halted: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		halted_o |-> (pi1_op_o == MEMNOOP)
	) else $error("pi1 operation issued while halted");

	halt_sticky: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		halted_o |=> halted_o
	) else $error("halted_o fell without reset");

endmodule

// ==== dv/pu_tb.sv ====
`timescale 1ns/1ps
/* Testbench for pu: random program, pi1 memory with random latency,
   instruction-set model and access and memory checks. */
module pu_tb;
	import pu_pkg::*;

	logic                 clk;
	logic                 arst_n;
	logic [ADDRBITSZ-1:0] rstaddr;
	logic [1:0]           pi1_op;
	logic [ADDRBITSZ-1:0] pi1_addr;
	logic [ARCHBITSZ-1:0] pi1_wdata;
	logic [ARCHBITSZ-1:0] pi1_rdata;
	logic                 pi1_rdy;
	logic                 halted;

	logic [ARCHBITSZ-1:0] mem [1024];
	logic [ARCHBITSZ-1:0] model_mem [1024];
	logic [1:0]           exp_op [$];
	logic [ADDRBITSZ-1:0] exp_addr [$];
	logic [ARCHBITSZ-1:0] exp_data [$];
	int                   exp_pos;
	int                   check_count;
	int                   error_count;
	integer               seed;
	logic [1:0]           delay;
	bit                   busy;
	bit                   ok;
	int                   seen;

	pu i_dut (
		.clk_i(clk), .arst_n_i(arst_n), .rstaddr_i(rstaddr),
		.pi1_op_o(pi1_op), .pi1_addr_o(pi1_addr), .pi1_data_o(pi1_wdata),
		.pi1_data_i(pi1_rdata), .pi1_rdy_i(pi1_rdy), .halted_o(halted)
	);

	bind pu_sequencer pu_properties i_properties (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .pi1_op_o(pi1_op_o),
		.pi1_addr_o(pi1_addr_o), .pi1_data_o(pi1_data_o),
		.pi1_rdy_i(pi1_rdy_i), .halted_o(halted_o)
	);

	always #20 clk = ~clk;

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR: %s", msg);
	endtask

	task automatic expect_access(input logic [1:0] op, input logic [ADDRBITSZ-1:0] addr,
		input logic [ARCHBITSZ-1:0] data);
		exp_op.push_back(op);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	// 64 random instructions then a halt, data region at word 512 and up.
	task automatic build_program();
		pu_instr_u  ins;
		logic [31:0] r;
		logic [3:0]  last_rd;
		bit          last_wrote;
		last_wrote = 0;
		last_rd = '0;
		for (int a = 0; a < 1024; a++) begin
			r = $random(seed);
			mem[a] = (a >= 512) ? r : (32'hc0de0000 | a);
		end
		for (int k = 0; k < 64; k++) begin
			ins = $random(seed);
			r = $random(seed);
			ins.r.opcode = 4'(r % 12);
			if (last_wrote && r[31]) begin
				ins.r.opcode = OPST;
				ins.i.rd = last_rd;
			end
			r = $random(seed);
			if (ins.r.opcode == OPLD || ins.r.opcode == OPST) begin
				ins.i.ra = '0;
				ins.i.imm = 20'(512 + r[8:0]);
			end else if (ins.r.opcode == OPBZ) begin
				ins.i.imm = 20'(r % (64 - k));
				if (r[31]) begin
					ins.i.ra = '0;
				end
			end
			last_wrote = (ins.r.opcode <= OPLD) && (ins.r.opcode != OPST);
			last_rd = ins.r.rd;
			mem[rstaddr + k] = ins;
		end
		ins = $random(seed);
		ins.r.opcode = OPHALT;
		mem[rstaddr + 64] = ins;
		model_mem = mem;
	endtask

	// Instruction-set model, records every bus access in order.
	task automatic run_model();
		pu_instr_u            ins;
		logic [31:0]          regs [16];
		logic [31:0]          a;
		logic [31:0]          b;
		logic [31:0]          imm;
		logic [31:0]          result;
		logic [ADDRBITSZ-1:0] pc;
		logic [ADDRBITSZ-1:0] addr;
		bit                   wr;
		bit                   running;
		int                   steps;
		for (int i = 0; i < 16; i++) begin
			regs[i] = '0;
		end
		pc = rstaddr;
		running = 1;
		steps = 0;
		while (running && steps < 200) begin
			steps++;
			ins = model_mem[pc[9:0]];
			expect_access(MEMREADOP, pc, '0);
			a = regs[ins.r.ra];
			b = regs[ins.r.rb];
			imm = {{12{ins.i.imm[19]}}, ins.i.imm};
			addr = a[ADDRBITSZ-1:0] + imm[ADDRBITSZ-1:0];
			wr = 1;
			result = '0;
			pc = pc + 1;
			case (ins.r.opcode)
				OPADD: result = a + b;
				OPSUB: result = a - b;
				OPAND: result = a & b;
				OPOR: result = a | b;
				OPXOR: result = a ^ b;
				OPSHL: result = a << b[4:0];
				OPSHR: result = a >> b[4:0];
				OPADDI: result = a + imm;
				OPLI: result = imm;
				OPLD: begin
					result = model_mem[addr[9:0]];
					expect_access(MEMREADOP, addr, '0);
				end
				OPST: begin
					wr = 0;
					model_mem[addr[9:0]] = regs[ins.i.rd];
					expect_access(MEMWRITEOP, addr, regs[ins.i.rd]);
				end
				OPBZ: begin
					wr = 0;
					if (a == '0) begin
						pc = pc + imm[ADDRBITSZ-1:0];
					end
				end
				default: begin
					wr = 0;
					running = 0;
				end
			endcase
			if (wr && ins.r.rd != '0) begin
				regs[ins.r.rd] = result;
			end
		end
		if (running) begin
			report_error("model did not reach the halt instruction");
		end
	endtask

	task automatic complete_access();
		logic [9:0] idx;
		idx = pi1_addr[9:0];
		if (pi1_addr > 1023) begin
			report_error("bus access outside the memory model");
		end
		if (pi1_op == MEMREADOP) begin
			pi1_rdata = mem[idx];
		end else if (pi1_op == MEMWRITEOP) begin
			mem[idx] = pi1_wdata;
		end else begin
			report_error("unknown bus operation");
		end
		compare_value("halted_o", 32'(halted), 32'h0);
		if (exp_pos < exp_op.size()) begin
			compare_value("pi1_op_o", 32'(pi1_op), 32'(exp_op[exp_pos]));
			compare_value("pi1_addr_o", 32'(pi1_addr), 32'(exp_addr[exp_pos]));
			if (exp_op[exp_pos] == MEMWRITEOP) begin
				compare_value("pi1_data_o", pi1_wdata, exp_data[exp_pos]);
			end
		end else begin
			report_error("bus access after the end of the expected sequence");
		end
		exp_pos++;
	endtask

	// Memory side of pi1, rdy is raised after 0 to 3 waiting cycles.
	always @(negedge clk) begin : responder
		logic [31:0] r;
		if (pi1_rdy) begin
			pi1_rdy = 1'b0;
			busy = 0;
		end else if (arst_n && pi1_op != MEMNOOP) begin
			if (!busy) begin
				r = $random(seed);
				delay = r[1:0];
				busy = 1;
			end
			if (delay == 0) begin
				complete_access();
				pi1_rdy = 1'b1;
			end else begin
				delay--;
			end
		end
	end

	initial begin
		seed = 32'h2f7e69ee;
		clk = 1'b0;
		arst_n = 1'b0;
		pi1_rdy = 1'b0;
		pi1_rdata = '0;
		busy = 0;
		delay = '0;
		exp_pos = 0;
		check_count = 0;
		error_count = 0;
		rstaddr = ADDRBITSZ'($unsigned($random(seed)) % 8);
		build_program();
		run_model();
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		ok = 0;
		for (int c = 0; c < 5000 && !ok; c++) begin
			@(negedge clk);
			ok = (exp_pos >= exp_op.size());
		end
		if (!ok) begin
			report_error("timeout while waiting for the program's bus accesses");
		end else begin
			ok = 0;
			for (int c = 0; c < 20 && !ok; c++) begin
				@(negedge clk);
				ok = halted;
			end
			if (!ok) begin
				report_error("timeout while waiting for halted_o to rise");
			end
		end
		if (ok) begin
			seen = exp_pos;
			repeat (50) @(negedge clk);
			compare_value("access_count", 32'(exp_pos), 32'(seen));
			for (int a = 512; a < 1024; a++) begin
				compare_value($sformatf("mem[%0d]", a), mem[a], model_mem[a]);
			end
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
design/pu_pkg.sv
design/pu_sequencer.sv
design/pu_decode.sv
design/pu_execute.sv
design/pu_result.sv
design/pu.sv
dv/pu_properties.sv
dv/pu_tb.sv
